/* Makefile */
SIM      = verilator
TOP      = gpuTb
FILELIST = build.f
FLAGS    = --binary --timing --assert -Wno-fatal
RUNFLAGS = +verilator+error+limit+100
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))
DATA     = verif/rowInput.txt
PASSMSG  = Test completed successfully

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: $(BIN) $(DATA)
	@out="$$(./$(BIN) $(RUNFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

/* build.f */
hw/gpuPkg.sv
hw/lcdRegs.sv
hw/rowCapture.sv
hw/pixelShade.sv
hw/fbWriter.sv
hw/gpuTop.sv
verif/gpuTop_checker.sv
verif/fbMonitor.sv
verif/gpuTb.sv

/* hw/fbWriter.sv */
`timescale 1ns/10ps

// packs eight shades into one frame-buffer word, owns the write address
module fbWriter import gpuPkg::*;
#(
  parameter int FbWords = FbWordsDefault
)
(
  input  logic                       clock,
  input  logic                       rstN,
  input  hostWrT                     hostWr,
  input  shadeT [PixelsPerWord-1:0]  shades,
  input  logic                       shadeValid,
  output logic                       fbWe,
  output logic [15:0]                fbData,  // pixel i at bits 2i+1:2i
  output logic [$clog2(FbWords)-1:0] fbAddr
);

  localparam int AddrW = $clog2(FbWords);
  localparam logic [AddrW-1:0] LastAddr = AddrW'(FbWords - 1);

  logic [AddrW-1:0] nextAddr; // target of the coming write
  logic             restart;

  assign restart = hostWr.we && (hostWr.sel == FbRestart);

  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      fbWe     <= 1'b0;
      fbData   <= '0;
      fbAddr   <= '0;
      nextAddr <= '0;
    end
    else
    begin
      fbWe <= shadeValid; // one pulse per row
      if (shadeValid)
      begin
        fbData <= shades;
        fbAddr <= nextAddr;
      end
      // restart beats a same-edge step
      if (restart)
        nextAddr <= '0;
      else if (shadeValid)
        nextAddr <= (nextAddr == LastAddr) ? '0 : nextAddr + 1'b1;
    end
  end

endmodule

/* hw/gpuPkg.sv */
package gpuPkg;

  //////////////////////////////
  // host register map
  //////////////////////////////
  typedef enum logic [3:0] {
    Lcdc      = 4'd0,
    Scy       = 4'd1,
    Scx       = 4'd2,
    Lyc       = 4'd3,
    Bgp       = 4'd4,
    Obp0      = 4'd5,
    Obp1      = 4'd6,
    Wy        = 4'd7,
    Wx        = 4'd8,
    TileHi    = 4'd9,  // background bit planes
    TileLo    = 4'd10,
    SprHi     = 4'd11, // sprite bit planes
    SprLo     = 4'd12,
    SprAttr   = 4'd13,
    Commit    = 4'd14, // push the loaded row down the pipe
    FbRestart = 4'd15  // next frame-buffer write goes to 0
  } regSelE;

  localparam int PixelsPerWord = 8;    // one tile row
  localparam int FbWordsDefault = 2880; // 160x144 pixels, 8 per word

  typedef logic [1:0] shadeT;          // 0 lightest .. 3 darkest
  typedef shadeT [3:0] paletteT;       // entry n at bits 2n+1:2n

  // lcd control flags, msb first
  typedef struct packed {
    logic displayOn;  // 7
    logic winMapSel;
    logic winOn;
    logic tileDataSel;
    logic bgMapSel;
    logic objSize;
    logic objOn;      // 1
    logic bgOn;
  } lcdcT;

  // sprite attribute byte
  typedef struct packed {
    logic       behindBg;
    logic       yFlip;
    logic       xFlip;
    logic       palSel;   // 1 picks OBP1
    logic [3:0] rsvd;
  } objAttrT;

  // one host data byte, read per select
  typedef union packed {
    paletteT    pal;
    lcdcT       lcdc;
    objAttrT    attr;
    logic [7:0] raw;
  } regByteU;

  typedef struct packed {
    logic    we;    // write strobe
    regSelE  sel;
    regByteU data;
  } hostWrT;

  typedef struct packed {
    lcdcT       lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    paletteT    bgp;
    paletteT    obp0;
    paletteT    obp1;
    logic [7:0] wy;
    logic [7:0] wx;
  } lcdRegsT;

  // one committed row, palettes frozen at commit
  typedef struct packed {
    logic [7:0] bgHi;
    logic [7:0] bgLo;
    logic [7:0] sprHi;
    logic [7:0] sprLo;
    paletteT    bgp;
    paletteT    sprPal;   // obp0 or obp1 per attribute
    logic       objOn;
  } rowT;

endpackage

/* hw/gpuTop.sv */
`timescale 1ns/10ps

// pixel path top: registers, row feeder, eight shaders, frame-buffer writer
module gpuTop import gpuPkg::*;
#(
  parameter int FbWords = FbWordsDefault
)
(
  input  logic                       clock,
  input  logic                       rstN,
  input  hostWrT                     hostWr,
  output lcdRegsT                    regs,
  output logic                       fbWe,
  output logic [15:0]                fbData,
  output logic [$clog2(FbWords)-1:0] fbAddr
);

  rowT                       row;
  logic                      rowValid;
  shadeT [PixelsPerWord-1:0] shades;
  logic [PixelsPerWord-1:0]  shadeValid; // lanes run in lockstep

  //////////////////////////////
  // host side
  //////////////////////////////
  lcdRegs lcdRegs_inst (
    .clock  (clock),
    .rstN   (rstN),
    .hostWr (hostWr),
    .regs   (regs)
  );

  rowCapture rowCapture_inst (
    .clock    (clock),
    .rstN     (rstN),
    .hostWr   (hostWr),
    .regs     (regs),
    .row      (row),
    .rowValid (rowValid)
  );

  //////////////////////////////
  // shading lanes
  //////////////////////////////
  for (genvar lane = 0; lane < PixelsPerWord; lane++)
  begin : gShade
    pixelShade #(.Lane(lane)) pixelShade_inst (
      .clock      (clock),
      .rstN       (rstN),
      .row        (row),
      .rowValid   (rowValid),
      .shade      (shades[lane]),
      .shadeValid (shadeValid[lane])
    );
  end

  fbWriter #(.FbWords(FbWords)) fbWriter_inst (
    .clock      (clock),
    .rstN       (rstN),
    .hostWr     (hostWr),
    .shades     (shades),
    .shadeValid (shadeValid[0]), // lane 0 speaks for all
    .fbWe       (fbWe),
    .fbData     (fbData),
    .fbAddr     (fbAddr)
  );

endmodule

/* hw/lcdRegs.sv */
`timescale 1ns/10ps

// display control and palette registers, host side only
module lcdRegs import gpuPkg::*;
(
  input  logic    clock,
  input  logic    rstN,
  input  hostWrT  hostWr,
  output lcdRegsT regs
);

  //////////////////////////////
  // byte registers
  //////////////////////////////
  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      regs <= '0; // display off, palettes all white
    end
    else if (hostWr.we)
    begin
      case (hostWr.sel)
        Lcdc:    regs.lcdc <= hostWr.data.lcdc;
        Scy:     regs.scy  <= hostWr.data.raw;  // scroll y
        Scx:     regs.scx  <= hostWr.data.raw;  // scroll x
        Lyc:     regs.lyc  <= hostWr.data.raw;
        // palette bytes, four 2-bit entries
        Bgp:     regs.bgp  <= hostWr.data.pal;
        Obp0:    regs.obp0 <= hostWr.data.pal;
        Obp1:    regs.obp1 <= hostWr.data.pal;
        // window origin
        Wy:      regs.wy   <= hostWr.data.raw;
        Wx:      regs.wx   <= hostWr.data.raw;
        default:
        begin
          // row and frame-buffer selects handled downstream
        end
      endcase
    end
  end

endmodule

/* hw/pixelShade.sv */
`timescale 1ns/10ps

// one pixel lane: palette lookup, sprite over background
module pixelShade import gpuPkg::*;
#(
  parameter int Lane = 0  // bit position in the tile bytes
)
(
  input  logic  clock,
  input  logic  rstN,
  input  rowT   row,
  input  logic  rowValid,
  output shadeT shade,
  output logic  shadeValid
);

  logic [1:0] bgIdx;
  logic [1:0] sprIdx;
  logic       sprShows;

  assign bgIdx    = {row.bgHi[Lane], row.bgLo[Lane]};   // hi plane is msb
  assign sprIdx   = {row.sprHi[Lane], row.sprLo[Lane]};
  assign sprShows = row.objOn && (sprIdx != 2'd0);      // index 0 is see-through

  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      shade      <= '0;
      shadeValid <= 1'b0;
    end
    else
    begin
      shadeValid <= rowValid;
      if (rowValid)
        shade <= sprShows ? row.sprPal[sprIdx] : row.bgp[bgIdx];
    end
  end

endmodule

/* hw/rowCapture.sv */
`timescale 1ns/10ps

// tile row staging, one row word out per commit
module rowCapture import gpuPkg::*;
(
  input  logic    clock,
  input  logic    rstN,
  input  hostWrT  hostWr,
  input  lcdRegsT regs,
  output rowT     row,
  output logic    rowValid
);

  logic [7:0] bgHi;
  logic [7:0] bgLo;
  logic [7:0] sprHi;
  logic [7:0] sprLo;
  objAttrT    attr;
  logic       commitOk;

  // commits are dropped while the lcd is off
  assign commitOk = hostWr.we && (hostWr.sel == Commit) && regs.lcdc.displayOn;

  //////////////////////////////
  // staged bytes
  //////////////////////////////
  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      bgHi  <= '0;
      bgLo  <= '0;
      sprHi <= '0;
      sprLo <= '0;
      attr  <= '0;
    end
    else if (hostWr.we)
    begin
      case (hostWr.sel)
        TileHi:  bgHi  <= hostWr.data.raw;
        TileLo:  bgLo  <= hostWr.data.raw;
        SprHi:   sprHi <= hostWr.data.raw;
        SprLo:   sprLo <= hostWr.data.raw;
        SprAttr: attr  <= hostWr.data.attr;
        default:
        begin
          // other selects are not row data
        end
      endcase
    end
  end

  //////////////////////////////
  // row word
  //////////////////////////////
  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      row      <= '0;
      rowValid <= 1'b0;
    end
    else
    begin
      rowValid <= commitOk; // single-cycle pulse
      if (commitOk)
      begin
        row.bgHi   <= bgHi;
        row.bgLo   <= bgLo;
        row.sprHi  <= sprHi;
        row.sprLo  <= sprLo;
        row.bgp    <= regs.bgp;  // palettes frozen here
        row.sprPal <= attr.palSel ? regs.obp1 : regs.obp0;
        row.objOn  <= regs.lcdc.objOn;
      end
    end
  end

endmodule

/* verif/fbMonitor.sv */
`timescale 1ns/10ps

// watches the frame-buffer port and the register outputs and does all comparing
module fbMonitor import gpuPkg::*;
#(
  parameter int FbWords = FbWordsDefault
)
(
  input logic                       clock,
  input logic                       fbWe,
  input logic [15:0]                fbData,
  input logic [$clog2(FbWords)-1:0] fbAddr,
  input lcdRegsT                    regs,
  input lcdRegsT                    expRegs   // model from the stimulus side
);

  localparam int AddrW = $clog2(FbWords);

  typedef struct packed {
    logic [15:0]      word;
    logic [AddrW-1:0] addr;
  } fbWriteT;

  fbWriteT expQ[$];          // oldest commit first
  lcdRegsT seenRegs;
  lcdRegsT seenExp;
  string   testName = "none";
  int      testCount = 0;
  int      testWrites = 0;
  int      testErrors = 0;
  int      totalWrites = 0;
  int      errorCount = 0;

  task automatic expectWrite(input logic [15:0] word, input int addr);
    fbWriteT entry;
    entry.word = word;
    entry.addr = AddrW'(addr);
    expQ.push_back(entry);
  endtask

  function automatic int pending();
    return expQ.size();
  endfunction

  task automatic noteError();
    testErrors++;
    errorCount++;
  endtask

  task automatic beginTest(input string name);
    testName   = name;
    testWrites = 0;
    testErrors = 0;
    testCount++;
  endtask

  task automatic endTest();
    if (expQ.size() != 0)
    begin
      $display("test %s: %0d expected writes never arrived", testName, expQ.size());
      noteError();
      expQ.delete();
    end
    $display("test %s %0d writes, %0d errors", testName, testWrites, testErrors);
  endtask

  task automatic printTotals(input int assertFails);
    $display("totals: %0d tests, %0d writes, %0d errors, %0d assertion failures",
             testCount, totalWrites, errorCount, assertFails);
  endtask

  //////////////////////////////
  // compare at the falling edge
  //////////////////////////////
  always @(negedge clock)
  begin : watch
    fbWriteT want;
    if (fbWe)
    begin
      testWrites++;
      totalWrites++;
      if (expQ.size() == 0)
      begin
        $display("unexpected frame-buffer write of %h to address %0d at %0t",
                 fbData, fbAddr, $time);
        noteError();
      end
      else
      begin
        want = expQ.pop_front();
        if (fbData !== want.word || fbAddr !== want.addr)
        begin
          $display("Mismatch at %0t: fb write %h at %0d, expected %h at %0d",
                   $time, fbData, fbAddr, want.word, want.addr);
          noteError();
        end
      end
    end
    // registers checked whenever either side moves
    if (regs !== seenRegs || expRegs !== seenExp)
    begin
      if (regs !== expRegs)
      begin
        $display("Mismatch at %0t: regs %h, expected %h", $time, regs, expRegs);
        noteError();
      end
      seenRegs = regs;
      seenExp  = expRegs;
    end
  end

endmodule

/* verif/gpuTb.sv */
`timescale 1ns/10ps

// clock, reset, file-driven host stimulus and the expected-write model
module gpuTb import gpuPkg::*;
();

  localparam int    FbWords   = 6;     // tiny frame buffer so the stream test wraps
  localparam int    AddrW     = $clog2(FbWords);
  localparam string InputFile = "verif/rowInput.txt";

  logic             clock;
  logic             rstN;
  hostWrT           hostWr;
  lcdRegsT          regs;
  logic             fbWe;
  logic [15:0]      fbData;
  logic [AddrW-1:0] fbAddr;

  lcdRegsT expRegs;            // register model as seen after the write edge
  int      expAddr;            // next expected frame-buffer address
  int      cycleCount = 0;
  int      cycleLimit = 0;
  int      fileErrors = 0;

  gpuTop #(.FbWords(FbWords)) gpuTop_inst (
    .clock  (clock),
    .rstN   (rstN),
    .hostWr (hostWr),
    .regs   (regs),
    .fbWe   (fbWe),
    .fbData (fbData),
    .fbAddr (fbAddr)
  );

  fbMonitor #(.FbWords(FbWords)) fbMonitor_inst (
    .clock   (clock),
    .fbWe    (fbWe),
    .fbData  (fbData),
    .fbAddr  (fbAddr),
    .regs    (regs),
    .expRegs (expRegs)
  );

  bind gpuTop gpuTop_checker #(.FbWords(FbWords)) gpuTop_checker_inst (
    .clock  (clock),
    .rstN   (rstN),
    .hostWr (hostWr),
    .regs   (regs),
    .fbWe   (fbWe),
    .fbAddr (fbAddr)
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock)
    cycleCount <= cycleCount + 1;

  //////////////////////////////
  // host side helpers
  //////////////////////////////
  task automatic driveStrobe(input regSelE sel, input logic [7:0] data);
    hostWr.we       = 1'b1;
    hostWr.sel      = sel;
    hostWr.data.raw = data;
    @(posedge clock);   // strobe taken here
    #1;
  endtask

  task automatic updateModel(input regSelE sel, input logic [7:0] data);
    case (sel)
      Lcdc:      expRegs.lcdc = lcdcT'(data);
      Scy:       expRegs.scy  = data;
      Scx:       expRegs.scx  = data;
      Lyc:       expRegs.lyc  = data;
      Bgp:       expRegs.bgp  = paletteT'(data);
      Obp0:      expRegs.obp0 = paletteT'(data);
      Obp1:      expRegs.obp1 = paletteT'(data);
      Wy:        expRegs.wy   = data;
      Wx:        expRegs.wx   = data;
      FbRestart: expAddr      = 0;
      default:   ;
    endcase
  endtask

  // let queued rows land and leave room for a stray write
  task automatic drainTest();
    int waited;
    hostWr.we = 1'b0;
    waited = 0;
    while (fbMonitor_inst.pending() != 0 && waited < 8)
    begin
      @(posedge clock);
      waited++;
    end
    repeat (4) @(posedge clock);
    #1;
    fbMonitor_inst.endTest();
  endtask

  function automatic int countLines();
    int               fd;
    int               lines;
    logic [8*128-1:0] lineBuf;
    lines = 0;
    fd = $fopen(InputFile, "r");
    if (fd != 0)
    begin
      while ($fgets(lineBuf, fd) != 0)
        lines++;
      $fclose(fd);
    end
    return lines;
  endfunction

  //////////////////////////////
  // data file walk
  //////////////////////////////
  task automatic runFile();
    int               fd;
    int               code;
    bit               inTest;
    string            kind;
    string            name;
    logic [3:0]       sel;
    logic [7:0]       data;
    logic [15:0]      word;
    logic [8*128-1:0] restOfLine;
    inTest = 1'b0;
    fd = $fopen(InputFile, "r");
    if (fd == 0)
    begin
      $display("could not open %s, no stimulus was run", InputFile);
      fileErrors++;
    end
    else
    begin
      while ($fscanf(fd, "%s", kind) == 1)
      begin
        if (kind == "#")
          code = $fgets(restOfLine, fd);   // column notes
        else if (kind == "t")
        begin
          if (inTest)
            drainTest();
          code = $fscanf(fd, "%s", name);
          fbMonitor_inst.beginTest(name);
          inTest = 1'b1;
        end
        else if (kind == "w")
        begin
          code = $fscanf(fd, "%h %h", sel, data);
          driveStrobe(regSelE'(sel), data);
          updateModel(regSelE'(sel), data);
        end
        else if (kind == "c")
        begin
          code = $fscanf(fd, "%h", word);
          driveStrobe(Commit, 8'h00);
          if (expRegs.lcdc.displayOn)   // lcd off drops the row
          begin
            fbMonitor_inst.expectWrite(word, expAddr);
            expAddr = (expAddr == FbWords - 1) ? 0 : expAddr + 1;
          end
        end
        else
        begin
          $display("unknown line kind '%s' in %s", kind, InputFile);
          fileErrors++;
          code = $fgets(restOfLine, fd);
        end
      end
      if (inTest)
        drainTest();
      $fclose(fd);
    end
  endtask

  //////////////////////////////
  // main flow
  //////////////////////////////
  initial
  begin : mainFlow
    int assertFails;
    rstN       = 1'b0;
    hostWr     = '0;
    expRegs    = '0;
    expAddr    = 0;
    cycleLimit = 4 * countLines() + 64;
    repeat (16) @(posedge clock);
    #1;
    rstN = 1'b1;
    runFile();
    assertFails = gpuTop_inst.gpuTop_checker_inst.failCount;
    fbMonitor_inst.printTotals(assertFails);
    if (fbMonitor_inst.errorCount + assertFails + fileErrors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin : watchdog
    wait (cycleLimit > 0);
    wait (cycleCount >= cycleLimit);
    $display("timeout after %0d cycles, the run did not finish", cycleLimit);
    $display("Test failed");
    $finish;
  end

endmodule

/* verif/gpuTop_checker.sv */
`timescale 1ns/10ps

// protocol rules on the pixel path, bound into gpuTop
module gpuTop_checker import gpuPkg::*;
#(
  parameter int FbWords = FbWordsDefault
)
(
  input logic                       clock,
  input logic                       rstN,
  input hostWrT                     hostWr,
  input lcdRegsT                    regs,
  input logic                       fbWe,
  input logic [$clog2(FbWords)-1:0] fbAddr
);

  localparam int AddrW = $clog2(FbWords);

  logic             commitOk;
  logic             restartQ;   // restart seen one edge late
  logic             havePrev;   // at least one write since reset
  logic             skipStep;   // restart landed between two writes
  logic [AddrW-1:0] prevAddr;
  logic [AddrW-1:0] stepAddr;
  int               failCount = 0;

  assign commitOk = hostWr.we && (hostWr.sel == Commit) && regs.lcdc.displayOn;
  assign stepAddr = (prevAddr == AddrW'(FbWords - 1)) ? '0 : prevAddr + 1'b1;

  //////////////////////////////
  // write history
  //////////////////////////////
  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      restartQ <= 1'b0;
      havePrev <= 1'b0;
      skipStep <= 1'b0;
      prevAddr <= '0;
    end
    else
    begin
      restartQ <= hostWr.we && (hostWr.sel == FbRestart);
      if (fbWe)
      begin
        prevAddr <= fbAddr;
        havePrev <= 1'b1;
        skipStep <= restartQ; // same-edge restart hits the next write
      end
      else if (restartQ)
        skipStep <= 1'b1;
    end
  end

  //////////////////////////////
  // rules
  //////////////////////////////
  quietInReset: assert property (@(posedge clock) !rstN |-> !fbWe)
    else
    begin
      $error("frame-buffer write while in reset");
      failCount++;
    end

  // three edges from accepted commit to the write, both ways
  commitLatency: assert property (@(posedge clock) disable iff (!rstN)
    fbWe == $past(commitOk, 3))
    else
    begin
      $error("fbWe does not trail an accepted commit by 3 edges");
      failCount++;
    end

  addrStep: assert property (@(posedge clock) disable iff (!rstN)
    (fbWe && havePrev && !skipStep) |-> (fbAddr == stepAddr))
    else
    begin
      $error("frame-buffer address did not step by one");
      failCount++;
    end

endmodule

/* verif/rowInput.txt */
# t <test name> | w <select> <data byte> | c <expected fbData>, all hex
# select 0 lcdc, 1-3 scy scx lyc, 4-6 bgp obp0 obp1, 9-c tile bytes, d attr, f restart
t regs
w 0 80
w 1 11
w 2 22
w 3 33
w 4 e4
w 5 1b
w 6 d2
w 7 77
w 8 88
t background
w 4 9c
w 9 cc
w a aa
c 9c9c
t sprite
w 0 82
w b c0
w c a0
w d 00
c 189c
w d 10
c d09c
t gating
w 0 02
c 0000
w 0 80
c 9c9c
w 4 e4
c e4e4
t stream
c e4e4
c e4e4
c e4e4
t restart
w f 00
c e4e4
c e4e4
